/* all.f */
hdl/fetch_cfg_pkg.sv
hdl/predict_pkg.sv
hdl/pc_indexed_table.sv
hdl/branch_predictor.sv
hdl/pc_sequencer.sv
hdl/fetch_stage.sv
hdl/fetch_front_end.sv
test/fetch_front_end_props.sv
test/tb_fetch_front_end.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator, runs it and
# decides pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f all.f --top-module tb_fetch_front_end \
    -o tb_fetch_front_end > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_fetch_front_end > sim.log 2>&1
cat sim.log
grep -qx "Simulation passed" sim.log && exit 0 || exit 1

/* test/tb_fetch_front_end.sv */
// ==========================================================================
// Fetch front end testbench
// Drives LFSR based fetch, trap and branch resolution traffic and checks
// every cycle against a model of the PC, the predictor tables and the
// fetch stage register
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front_end
    import fetch_cfg_pkg::*;
    import predict_pkg::*;
();

    localparam int    CLK_PERIOD      = 100;
    localparam int    TABLE_ENTRIES   = 32;
    localparam int    TEST_CYCLES     = 1 + 300 + 200 + 300 + 400 + 300;
    localparam int    WATCHDOG_CYCLES = TEST_CYCLES + 3 + 50;
    // Traps and branches stay in a small code region so that entries get reused
    localparam addr_t REGION          = 32'h0000_0040;

    logic   clk_i;
    logic   rst_n_i;
    logic   fetch_valid_i;
    instr_t fetch_instruction_i;
    logic   stall_i;
    logic   branch_flush_i;
    logic   exception_i;
    logic   interrupt_i;
    addr_t  handler_pc_i;
    logic   executed_i;
    logic   branch_i;
    logic   jump_i;
    logic   taken_i;
    logic   speculative_i;
    addr_t  instr_address_i;
    addr_t  branch_target_addr_i;
    logic   fetch_o;
    addr_t  fetch_address_o;
    logic   mispredicted_o;
    logic   if_valid_o;
    instr_t if_instruction_o;
    addr_t  if_pc_o;
    logic   if_compressed_o;
    logic   if_speculative_o;

    // Model state and the expected values of the current cycle
    logic [31:0] lfsr_q;
    addr_t       m_pc;
    counter_t    m_counter [TABLE_ENTRIES];
    logic        m_btb_valid [TABLE_ENTRIES];
    addr_t       m_btb_tag [TABLE_ENTRIES];
    addr_t       m_btb_target [TABLE_ENTRIES];
    logic        m_if_valid;
    instr_t      m_if_instr;
    addr_t       m_if_pc;
    logic        m_if_compressed;
    logic        m_if_speculative;
    logic        e_fetch;
    addr_t       e_addr;
    logic        e_mis;
    logic        e_pred;
    logic        e_comp;
    int          e_fidx;
    int          e_ridx;
    int          checks;
    int          errors;

    fetch_front_end #(
        .TABLE_ENTRIES (TABLE_ENTRIES)
    ) uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ======================================================================
    // Random source and memory contents
    // ======================================================================

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = step_lfsr(lfsr_q);
        end
        return v;
    endfunction

    // Every word of memory is a full encoding built from its own address
    function automatic instr_t memory_word(input addr_t addr);
        return {addr[15:0] ^ addr[31:16], addr[13:0], 2'b11};
    endfunction

    function automatic int table_index(input addr_t addr);
        return int'((addr >> 2) % TABLE_ENTRIES);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================

    task automatic reset_model();
        m_pc       = RESET_PC;
        m_if_valid = 1'b0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            m_counter[i]    = COUNTER_RESET;
            m_btb_valid[i]  = 1'b0;
            m_btb_tag[i]    = '0;
            m_btb_target[i] = '0;
        end
    endtask

    // Mode bits enable stall (0), trap (1), resolution (2), speculative (3)
    // and flush (4) traffic
    task automatic drive_inputs(input logic [4:0] mode);
        logic compressed;
        fetch_valid_i        = (take_bits(2) != 0);
        compressed           = (take_bits(1) != 0);
        // Flipping bit 0 turns the word into a 16 bit encoding
        fetch_instruction_i  = memory_word(m_pc) ^ (compressed ? 32'h1 : 32'h0);
        stall_i              = mode[0] && (take_bits(2) == 0);
        exception_i          = mode[1] && (take_bits(4) == 0);
        interrupt_i          = mode[1] && (take_bits(4) == 0);
        handler_pc_i         = REGION + (take_bits(4) << 2);
        executed_i           = mode[2] && (take_bits(2) == 0);
        jump_i               = (take_bits(2) == 0);
        branch_i             = !jump_i;
        taken_i              = (take_bits(1) != 0);
        speculative_i        = mode[3] && (take_bits(1) != 0);
        instr_address_i      = REGION + (take_bits(4) << 2);
        branch_target_addr_i = REGION + (take_bits(2) << 4);
        branch_flush_i       = mode[4] && (take_bits(3) == 0);
    endtask

    task automatic compute_expected();
        addr_t seq;
        logic  redirect;
        e_fidx   = table_index(m_pc);
        e_ridx   = table_index(instr_address_i);
        e_comp   = (fetch_instruction_i[1:0] != 2'b11);
        seq      = m_pc + ((e_comp && fetch_valid_i) ? CINSTR_STEP : INSTR_STEP);
        e_pred   = m_btb_valid[e_fidx] && (m_btb_tag[e_fidx] == m_pc)
                   && m_counter[e_fidx][1];
        redirect = taken_i || jump_i;
        e_mis    = executed_i && speculative_i
                   && (!redirect || (m_btb_target[e_ridx] != branch_target_addr_i));
        e_fetch  = 1'b1;
        if (exception_i || interrupt_i) begin
            e_addr = handler_pc_i;
        end else if (executed_i && redirect && (!speculative_i || e_mis)) begin
            e_addr = branch_target_addr_i;
        end else if (e_mis) begin
            e_addr = instr_address_i + INSTR_STEP;
        end else if (executed_i) begin
            e_addr = stall_i ? m_pc : seq;
        end else if (!stall_i) begin
            e_addr = e_pred ? m_btb_target[e_fidx] : seq;
        end else begin
            e_fetch = 1'b0;
            e_addr  = m_pc;
        end
    endtask

    task automatic check_outputs();
        check_value("fetch_o", 32'(fetch_o), 32'(e_fetch));
        check_value("fetch_address_o", fetch_address_o, e_addr);
        check_value("mispredicted_o", 32'(mispredicted_o), 32'(e_mis));
        check_value("if_valid_o", 32'(if_valid_o), 32'(m_if_valid));
        // The payload of an empty slot is left unchecked
        if (m_if_valid) begin
            check_value("if_instruction_o", if_instruction_o, m_if_instr);
            check_value("if_pc_o", if_pc_o, m_if_pc);
            check_value("if_compressed_o", 32'(if_compressed_o), 32'(m_if_compressed));
            check_value("if_speculative_o", 32'(if_speculative_o), 32'(m_if_speculative));
        end
    endtask

    // Applies the clock edge to the model with the inputs of this cycle
    task automatic update_model();
        if (executed_i && jump_i) begin
            m_counter[e_ridx] = COUNTER_TAKEN;
        end else if (executed_i && branch_i && taken_i && m_counter[e_ridx] != 2'd3) begin
            m_counter[e_ridx] = m_counter[e_ridx] + 2'd1;
        end else if (executed_i && branch_i && !taken_i && m_counter[e_ridx] != 2'd0) begin
            m_counter[e_ridx] = m_counter[e_ridx] - 2'd1;
        end
        if (executed_i && (jump_i || (branch_i && taken_i))) begin
            m_btb_valid[e_ridx]  = 1'b1;
            m_btb_tag[e_ridx]    = instr_address_i;
            m_btb_target[e_ridx] = branch_target_addr_i;
        end
        if (branch_flush_i || e_mis) begin
            m_if_valid = 1'b0;
        end else if (!stall_i) begin
            m_if_valid = fetch_valid_i;
        end
        if (!stall_i) begin
            m_if_instr       = e_comp ? {16'h0000, fetch_instruction_i[15:0]}
                                      : fetch_instruction_i;
            m_if_pc          = m_pc;
            m_if_compressed  = e_comp;
            m_if_speculative = e_pred;
        end
        m_pc = e_addr;
    endtask

    // ======================================================================
    // Cycle and test sequencing
    // ======================================================================

    task automatic begin_cycle(input logic [4:0] mode);
        drive_inputs(mode);
        compute_expected();
        @(negedge clk_i);
    endtask

    task automatic end_cycle();
        @(posedge clk_i);
        update_model();
        #1;
    endtask

    task automatic run_test(input string name, input int cycles, input logic [4:0] mode);
        int errors_before;
        errors_before = errors;
        for (int c = 0; c < cycles; c++) begin
            begin_cycle(mode);
            check_outputs();
            end_cycle();
        end
        $display("Test %s: %0d cycles, %0d errors", name, cycles, errors - errors_before);
    endtask

    initial begin
        lfsr_q               = 32'hb82c3ee9;
        checks               = 0;
        errors               = 0;
        rst_n_i              = 1'b0;
        fetch_valid_i        = 1'b0;
        fetch_instruction_i  = '0;
        stall_i              = 1'b0;
        branch_flush_i       = 1'b0;
        exception_i          = 1'b0;
        interrupt_i          = 1'b0;
        handler_pc_i         = '0;
        executed_i           = 1'b0;
        branch_i             = 1'b0;
        jump_i               = 1'b0;
        taken_i              = 1'b0;
        speculative_i        = 1'b0;
        instr_address_i      = '0;
        branch_target_addr_i = '0;
        reset_model();
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // First fetch after reset goes to address 0 with an empty stage
        // Nothing was requested during reset, so no memory response is valid
        drive_inputs(5'b00000);
        fetch_valid_i = 1'b0;
        compute_expected();
        @(negedge clk_i);
        check_value("fetch_address_o", fetch_address_o, 32'h0);
        check_value("fetch_o", 32'(fetch_o), 32'h1);
        check_value("if_valid_o", 32'(if_valid_o), 32'h0);
        check_outputs();
        end_cycle();
        $display("Test reset: 1 cycles, %0d errors", errors);

        run_test("sequential fetch", 300, 5'b00001);
        run_test("trap redirect", 200, 5'b00111);
        run_test("branch resolution", 300, 5'b00101);
        run_test("prediction training", 400, 5'b00110);
        run_test("mispredict and flush", 300, 5'b11111);

        $display("All tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_fetch_front_end

`default_nettype wire

/* test/fetch_front_end_props.sv */
// ==========================================================================
// Fetch front end properties
// Concurrent checks on trap redirects, misprediction flushes, stall
// behavior and the reset state of the fetch stage
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_front_end_props
    import fetch_cfg_pkg::*;
(
    input logic  clk_i,
    input logic  rst_n_i,
    input logic  stall_i,
    input logic  exception_i,
    input logic  interrupt_i,
    input addr_t handler_pc_i,
    input logic  executed_i,
    input logic  fetch_o,
    input addr_t fetch_address_o,
    input logic  mispredicted_o,
    input logic  if_valid_o,
    // Program counter register inside the top level
    input addr_t pc_i
);

    // A trap always wins, even over a stall or a resolution
    trap_redirect: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (exception_i || interrupt_i) |-> (fetch_o && (fetch_address_o == handler_pc_i)))
        else $error("Trap did not redirect the fetch bus to the handler");

    // The wrong path instruction in the stage is dropped
    mispredict_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mispredicted_o |=> !if_valid_o)
        else $error("Stage still valid after a misprediction");

    // With nothing to redirect it, a stall parks the fetch bus on the PC
    stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !exception_i && !interrupt_i && !executed_i)
        |-> (!fetch_o && (fetch_address_o == pc_i)))
        else $error("Fetch address moved during a stall");

    reset_clears_valid: assert property (@(posedge clk_i)
        !rst_n_i |=> !if_valid_o)
        else $error("Stage valid right after reset");

endmodule : fetch_front_end_props

bind fetch_front_end fetch_front_end_props props (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .stall_i         (stall_i),
    .exception_i     (exception_i),
    .interrupt_i     (interrupt_i),
    .handler_pc_i    (handler_pc_i),
    .executed_i      (executed_i),
    .fetch_o         (fetch_o),
    .fetch_address_o (fetch_address_o),
    .mispredicted_o  (mispredicted_o),
    .if_valid_o      (if_valid_o),
    .pc_i            (pc)
);

`default_nettype wire

/* hdl/fetch_front_end.sv */
// ==========================================================================
// Fetch front end
// Instruction fetch half of the CPU front end. The PC sequencer steers the
// fetch bus, the predictor supplies targets and the fetch stage registers
// each returned instruction for decode
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_front_end
    import fetch_cfg_pkg::*;
#(
    parameter int TABLE_ENTRIES = 32
) (
    input  logic   clk_i,
    input  logic   rst_n_i,
    // Fetch response
    input  logic   fetch_valid_i,
    input  instr_t fetch_instruction_i,
    // Pipeline control
    input  logic   stall_i,
    input  logic   branch_flush_i,
    // Traps
    input  logic   exception_i,
    input  logic   interrupt_i,
    input  addr_t  handler_pc_i,
    // Branch resolution
    input  logic   executed_i,
    input  logic   branch_i,
    input  logic   jump_i,
    input  logic   taken_i,
    input  logic   speculative_i,
    input  addr_t  instr_address_i,
    input  addr_t  branch_target_addr_i,
    // Fetch request and recovery
    output logic   fetch_o,
    output addr_t  fetch_address_o,
    output logic   mispredicted_o,
    // Fetch stage
    output logic   if_valid_o,
    output instr_t if_instruction_o,
    output addr_t  if_pc_o,
    output logic   if_compressed_o,
    output logic   if_speculative_o
);

    addr_t pc;
    logic  compressed;
    logic  predict_taken;
    addr_t predict_target;
    logic  mispredicted;

    assign mispredicted_o = mispredicted;

    pc_sequencer sequencer (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .stall_i              (stall_i),
        .exception_i          (exception_i),
        .interrupt_i          (interrupt_i),
        .handler_pc_i         (handler_pc_i),
        .executed_i           (executed_i),
        .jump_i               (jump_i),
        .taken_i              (taken_i),
        .speculative_i        (speculative_i),
        .instr_address_i      (instr_address_i),
        .branch_target_addr_i (branch_target_addr_i),
        .fetch_valid_i        (fetch_valid_i),
        .compressed_i         (compressed),
        .predict_taken_i      (predict_taken),
        .predict_target_i     (predict_target),
        .mispredicted_i       (mispredicted),
        .fetch_o              (fetch_o),
        .fetch_address_o      (fetch_address_o),
        .pc_o                 (pc)
    );

    // Prediction is looked up at the PC whose instruction is arriving now
    branch_predictor #(
        .TABLE_ENTRIES (TABLE_ENTRIES)
    ) predictor (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .pc_i                 (pc),
        .executed_i           (executed_i),
        .branch_i             (branch_i),
        .jump_i               (jump_i),
        .taken_i              (taken_i),
        .speculative_i        (speculative_i),
        .instr_address_i      (instr_address_i),
        .branch_target_addr_i (branch_target_addr_i),
        .predict_taken_o      (predict_taken),
        .predict_target_o     (predict_target),
        .mispredicted_o       (mispredicted)
    );

    fetch_stage stage (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .stall_i             (stall_i),
        .branch_flush_i      (branch_flush_i),
        .mispredicted_i      (mispredicted),
        .fetch_valid_i       (fetch_valid_i),
        .fetch_instruction_i (fetch_instruction_i),
        .pc_i                (pc),
        .speculative_i       (predict_taken),
        .compressed_o        (compressed),
        .if_valid_o          (if_valid_o),
        .if_instruction_o    (if_instruction_o),
        .if_pc_o             (if_pc_o),
        .if_compressed_o     (if_compressed_o),
        .if_speculative_o    (if_speculative_o)
    );

endmodule : fetch_front_end

`default_nettype wire

/* hdl/fetch_stage.sv */
// ==========================================================================
// Fetch stage
// Detects compressed encodings and registers the fetched instruction with
// its PC and flags, flushing on redirects and holding on stalls
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import fetch_cfg_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   stall_i,
    input  logic   branch_flush_i,
    input  logic   mispredicted_i,
    // Memory response for the current PC
    input  logic   fetch_valid_i,
    input  instr_t fetch_instruction_i,
    input  addr_t  pc_i,
    input  logic   speculative_i,
    // Early compressed flag for the sequencer
    output logic   compressed_o,
    // Stage register
    output logic   if_valid_o,
    output instr_t if_instruction_o,
    output addr_t  if_pc_o,
    output logic   if_compressed_o,
    output logic   if_speculative_o
);

    instr_t captured_instruction;

    // Full RISC-V encodings always end in 2'b11
    assign compressed_o = (fetch_instruction_i[1:0] != 2'b11);

    // Without a decompressor the 16 bit parcel is passed on raw
    assign captured_instruction = compressed_o ? {16'h0000, fetch_instruction_i[15:0]}
                                               : fetch_instruction_i;

    // Payload only moves when the pipeline advances
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            if_instruction_o <= captured_instruction;
            if_pc_o          <= pc_i;
            if_compressed_o  <= compressed_o;
            if_speculative_o <= speculative_i;
        end
    end

    // Flush has priority over stall, so a redirect kills a held slot
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            if_valid_o <= 1'b0;
        end else if (branch_flush_i || mispredicted_i) begin
            if_valid_o <= 1'b0;
        end else if (!stall_i) begin
            if_valid_o <= fetch_valid_i;
        end
    end

endmodule : fetch_stage

`default_nettype wire

/* hdl/pc_sequencer.sv */
// ==========================================================================
// PC sequencer
// Picks the next fetch address by fixed priority (trap, resolved branch,
// prediction, sequential step) and holds the program counter register
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pc_sequencer
    import fetch_cfg_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Pipeline control and traps
    input  logic  stall_i,
    input  logic  exception_i,
    input  logic  interrupt_i,
    input  addr_t handler_pc_i,
    // Branch resolution
    input  logic  executed_i,
    input  logic  jump_i,
    input  logic  taken_i,
    input  logic  speculative_i,
    input  addr_t instr_address_i,
    input  addr_t branch_target_addr_i,
    // Current fetch response
    input  logic  fetch_valid_i,
    input  logic  compressed_i,
    // From the predictor
    input  logic  predict_taken_i,
    input  addr_t predict_target_i,
    input  logic  mispredicted_i,
    // Fetch request
    output logic  fetch_o,
    output addr_t fetch_address_o,
    output addr_t pc_o
);

    addr_t pc_q;
    addr_t seq_address;

    // The compressed flag is only meaningful when memory returned a word
    assign seq_address = (compressed_i && fetch_valid_i) ? pc_q + CINSTR_STEP
                                                         : pc_q + INSTR_STEP;

    // ======================================================================
    // Next address priority
    // ======================================================================

    always_comb begin
        fetch_o         = 1'b0;
        fetch_address_o = pc_q;
        if (exception_i || interrupt_i) begin
            // Traps win even over a stall
            fetch_o         = 1'b1;
            fetch_address_o = handler_pc_i;
        end else if (executed_i) begin
            fetch_o = 1'b1;
            if (speculative_i && mispredicted_i) begin
                // Recover onto the path that was really taken
                if (taken_i || jump_i) begin
                    fetch_address_o = branch_target_addr_i;
                end else begin
                    fetch_address_o = instr_address_i + INSTR_STEP;
                end
            end else if (!speculative_i && (taken_i || jump_i)) begin
                fetch_address_o = branch_target_addr_i;
            end else if (!stall_i) begin
                // Correct prediction or fall through keeps streaming
                fetch_address_o = seq_address;
            end
        end else if (!stall_i) begin
            fetch_o         = 1'b1;
            fetch_address_o = predict_taken_i ? predict_target_i : seq_address;
        end
    end

    // The PC follows the fetch bus with one cycle of latency
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= fetch_address_o;
        end
    end

    assign pc_o = pc_q;

endmodule : pc_sequencer

`default_nettype wire

/* hdl/branch_predictor.sv */
// ==========================================================================
// Branch predictor
// Pattern history table of 2 bit counters plus a branch target buffer.
// Predicts at the current PC, flags mispredictions at resolution and
// trains both tables one clock after a branch or jump resolves
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module branch_predictor
    import fetch_cfg_pkg::*;
    import predict_pkg::*;
#(
    parameter int TABLE_ENTRIES = 32
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Current program counter
    input  addr_t pc_i,
    // Resolution from the back end
    input  logic  executed_i,
    input  logic  branch_i,
    input  logic  jump_i,
    input  logic  taken_i,
    input  logic  speculative_i,
    input  addr_t instr_address_i,
    input  addr_t branch_target_addr_i,
    // Prediction and recovery
    output logic  predict_taken_o,
    output addr_t predict_target_o,
    output logic  mispredicted_o
);

    counter_t   fetch_counter;
    counter_t   resolve_counter;
    counter_t   next_counter;
    btb_entry_t fetch_entry;
    btb_entry_t resolve_entry;
    btb_entry_t new_entry;
    logic       counter_wr_en;
    logic       target_wr_en;

    // ======================================================================
    // Lookup
    // ======================================================================

    // A hit needs a valid entry whose tag is exactly this PC
    assign predict_taken_o  = fetch_entry.valid && (fetch_entry.tag == pc_i)
                              && fetch_counter[1];
    assign predict_target_o = fetch_entry.target;

    // A speculated branch was wrong if it fell through, or if it went
    // somewhere other than the address the buffer supplied
    assign mispredicted_o = executed_i && speculative_i
                            && (!(taken_i || jump_i)
                                || (resolve_entry.target != branch_target_addr_i));

    // ======================================================================
    // Update
    // ======================================================================

    assign counter_wr_en = executed_i && (branch_i || jump_i);
    assign target_wr_en  = executed_i && ((branch_i && taken_i) || jump_i);

    // Jumps are always taken, so they jump straight to the strong state
    always_comb begin
        if (jump_i) begin
            next_counter = COUNTER_TAKEN;
        end else if (taken_i) begin
            next_counter = (resolve_counter == COUNTER_TAKEN) ? COUNTER_TAKEN
                                                              : resolve_counter + 2'd1;
        end else begin
            next_counter = (resolve_counter == COUNTER_MIN) ? COUNTER_MIN
                                                            : resolve_counter - 2'd1;
        end
    end

    assign new_entry = '{valid: 1'b1, tag: instr_address_i, target: branch_target_addr_i};

    pc_indexed_table #(
        .TABLE_ENTRIES (TABLE_ENTRIES),
        .entry_t       (counter_t)
    ) counter_table (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rd_addr_a_i   (pc_i),
        .rd_data_a_o   (fetch_counter),
        .rd_addr_b_i   (instr_address_i),
        .rd_data_b_o   (resolve_counter),
        .wr_en_i       (counter_wr_en),
        .wr_addr_i     (instr_address_i),
        .wr_data_i     (next_counter),
        .reset_value_i (COUNTER_RESET)
    );

    pc_indexed_table #(
        .TABLE_ENTRIES (TABLE_ENTRIES),
        .entry_t       (btb_entry_t)
    ) target_table (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rd_addr_a_i   (pc_i),
        .rd_data_a_o   (fetch_entry),
        .rd_addr_b_i   (instr_address_i),
        .rd_data_b_o   (resolve_entry),
        .wr_en_i       (target_wr_en),
        .wr_addr_i     (instr_address_i),
        .wr_data_i     (new_entry),
        .reset_value_i (BTB_ENTRY_RESET)
    );

endmodule : branch_predictor

`default_nettype wire

/* hdl/pc_indexed_table.sv */
// ==========================================================================
// PC indexed table
// Direct mapped storage indexed by the word address of a PC, with two
// combinational read ports and one synchronous write port
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pc_indexed_table
    import fetch_cfg_pkg::*;
#(
    parameter int  TABLE_ENTRIES = 32,
    parameter type entry_t       = logic
) (
    input  logic   clk_i,
    input  logic   rst_n_i,
    // Fetch side lookup
    input  addr_t  rd_addr_a_i,
    output entry_t rd_data_a_o,
    // Resolution side lookup
    input  addr_t  rd_addr_b_i,
    output entry_t rd_data_b_o,
    // Update port
    input  logic   wr_en_i,
    input  addr_t  wr_addr_i,
    input  entry_t wr_data_i,
    input  entry_t reset_value_i
);

    localparam int INDEX_BITS = $clog2(TABLE_ENTRIES);

    entry_t                entries_q [TABLE_ENTRIES];
    logic [INDEX_BITS-1:0] rd_index_a;
    logic [INDEX_BITS-1:0] rd_index_b;
    logic [INDEX_BITS-1:0] wr_index;

    // Bits 1:0 never select an entry, so a compressed instruction in the
    // upper half of a word shares the entry of that word
    assign rd_index_a = rd_addr_a_i[INDEX_BITS+1:2];
    assign rd_index_b = rd_addr_b_i[INDEX_BITS+1:2];
    assign wr_index   = wr_addr_i[INDEX_BITS+1:2];

    assign rd_data_a_o = entries_q[rd_index_a];
    assign rd_data_b_o = entries_q[rd_index_b];

    // Reset walks every entry back to the caller's reset value
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                entries_q[i] <= reset_value_i;
            end
        end else if (wr_en_i) begin
            entries_q[wr_index] <= wr_data_i;
        end
    end

endmodule : pc_indexed_table

`default_nettype wire

/* hdl/predict_pkg.sv */
// ==========================================================================
// Branch prediction package
// Saturating counter encoding for the pattern history table and the entry
// layout of the branch target buffer
// ==========================================================================

`default_nettype none

package predict_pkg;

    import fetch_cfg_pkg::*;

    // ======================================================================
    // Pattern history counters
    // ======================================================================

    // Two bit saturating counter, the upper bit is the taken prediction
    typedef logic [1:0] counter_t;

    // Strongly not taken, lower saturation point
    localparam counter_t COUNTER_MIN = 2'd0;

    // Weakly not taken, every counter starts here
    localparam counter_t COUNTER_RESET = 2'd1;

    // Strongly taken, upper saturation point and the value loaded on jumps
    localparam counter_t COUNTER_TAKEN = 2'd3;

    // ======================================================================
    // Branch target buffer
    // ======================================================================

    // The full branch address is kept as tag, so aliasing never predicts
    typedef struct packed {
        logic  valid;
        addr_t tag;
        addr_t target;
    } btb_entry_t;

    // Empty entry used to clear the buffer on reset
    localparam btb_entry_t BTB_ENTRY_RESET = '0;

endpackage : predict_pkg

`default_nettype wire

/* hdl/fetch_cfg_pkg.sv */
// ==========================================================================
// Fetch configuration package
// Address and instruction word types shared by the whole front end, with
// the program counter reset value and the two sequential increments
// ==========================================================================

`default_nettype none

package fetch_cfg_pkg;

    // ======================================================================
    // Data types
    // ======================================================================

    // Byte address on the instruction fetch bus
    typedef logic [31:0] addr_t;

    // Instruction word as returned by memory
    // A compressed instruction only occupies the lower 16 bits
    typedef logic [31:0] instr_t;

    // ======================================================================
    // Program counter constants
    // ======================================================================

    // The PC register sits one word below zero out of reset
    // The first sequential step then puts address 0 on the fetch bus
    localparam addr_t RESET_PC = 32'hffff_fffc;

    // Step for a full 32 bit instruction
    localparam addr_t INSTR_STEP = 32'd4;

    // Step for a 16 bit compressed instruction
    // Only applied when the memory actually returned a valid word
    localparam addr_t CINSTR_STEP = 32'd2;

endpackage : fetch_cfg_pkg

`default_nettype wire
